// File: hw/video_regs_pkg.sv
// extended port high bytes follow the tsconf map and the legacy opcodes sit on values no port decodes to
package video_regs_pkg;

    // **************************************************
    // port addresses
    // **************************************************
    localparam logic [7:0]  EXT_PORT_LO     = 8'hAF;
    localparam logic [7:0]  ZBORDER_PORT_LO = 8'hFE;
    localparam logic [15:0] ZVPAGE_PORT     = 16'h7FFD;

    // raster geometry, one column unit is two clocks
    localparam logic [7:0]  LINE_COLUMNS    = 8'd224;
    localparam logic [8:0]  FRAME_LINES     = 9'd320;

    localparam logic [7:0]  VPAGE_RESET     = 8'h05;
    localparam logic [7:0]  PALSEL_RESET    = 8'h0F;
    localparam logic [7:0]  HINT_RESET      = 8'd1;

    // **************************************************
    // register opcodes
    // **************************************************
    typedef enum logic [7:0] {
        REG_VCONF      = 8'h00,
        REG_VPAGE      = 8'h01,
        REG_GX_OFFS_L  = 8'h02,
        REG_GX_OFFS_H  = 8'h03,
        REG_GY_OFFS_L  = 8'h04,
        REG_GY_OFFS_H  = 8'h05,
        REG_TSCONF     = 8'h06,
        REG_PALSEL     = 8'h07,
        REG_BORDER     = 8'h0F,
        REG_TMPAGE     = 8'h16,
        REG_T0GPAGE    = 8'h17,
        REG_T1GPAGE    = 8'h18,
        REG_SGPAGE     = 8'h19,
        REG_HINT_BEG   = 8'h22,
        REG_VINT_BEG_L = 8'h23,
        REG_VINT_BEG_H = 8'h24,
        REG_T0X_OFFS_L = 8'h40,
        REG_T0X_OFFS_H = 8'h41,
        REG_T0Y_OFFS_L = 8'h42,
        REG_T0Y_OFFS_H = 8'h43,
        REG_T1X_OFFS_L = 8'h44,
        REG_T1X_OFFS_H = 8'h45,
        REG_T1Y_OFFS_L = 8'h46,
        REG_T1Y_OFFS_H = 8'h47,
        REG_ZVPAGE     = 8'hFD,    // legacy page format
        REG_ZBORDER    = 8'hFE     // legacy border format
    } video_reg_e;

    typedef struct packed {
        logic        valid;
        logic [15:0] addr;
        logic [7:0]  data;
    } cpu_wr_t;

    typedef struct packed {
        logic       valid;
        video_reg_e opcode;
        logic [7:0] data;
    } port_wr_t;

    typedef struct packed {
        logic [7:0] border;
        logic [7:0] vpage;
        logic [7:0] vconf;
        logic [7:0] palsel;
        logic [7:0] tsconf;
        logic [7:0] tmpage;
        logic [7:0] t0gpage;
        logic [7:0] t1gpage;
        logic [7:0] sgpage;
        logic [7:0] hint_beg;
        logic [8:0] gx_offs;
        logic [8:0] gy_offs;
        logic [8:0] t0x_offs;
        logic [8:0] t0y_offs;
        logic [8:0] t1x_offs;
        logic [8:0] t1y_offs;
        logic [8:0] vint_beg;
    } video_params_t;

    typedef struct packed {
        logic [8:0] line;
        logic [7:0] column;
    } raster_pos_t;

endpackage

// File: hw/port_decoder.sv
// one write per clock with a fixed one cycle latency and writes to unknown or undefined ports are dropped
`timescale 1ns/1ns

module port_decoder
    import video_regs_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  cpu_wr_t  cpu_wr,
    output port_wr_t dec_wr
);

    video_reg_e ext_opcode;
    logic       ext_match;
    logic       zborder_match;
    logic       zvpage_match;
    logic       dec_valid;
    video_reg_e dec_opcode;
    logic [7:0] dec_data;

    // high bytes that name a real extended register
    function automatic logic ext_defined(video_reg_e op);
        case (op)
            REG_VCONF, REG_VPAGE, REG_GX_OFFS_L, REG_GX_OFFS_H,
            REG_GY_OFFS_L, REG_GY_OFFS_H, REG_TSCONF, REG_PALSEL,
            REG_BORDER, REG_TMPAGE, REG_T0GPAGE, REG_T1GPAGE,
            REG_SGPAGE, REG_HINT_BEG, REG_VINT_BEG_L, REG_VINT_BEG_H,
            REG_T0X_OFFS_L, REG_T0X_OFFS_H, REG_T0Y_OFFS_L, REG_T0Y_OFFS_H,
            REG_T1X_OFFS_L, REG_T1X_OFFS_H, REG_T1Y_OFFS_L, REG_T1Y_OFFS_H:
                ext_defined = 1'b1;
            default:
                ext_defined = 1'b0;
        endcase
    endfunction

    assign ext_opcode    = video_reg_e'(cpu_wr.addr[15:8]);
    assign ext_match     = (cpu_wr.addr[7:0] == EXT_PORT_LO) && ext_defined(ext_opcode);
    assign zborder_match = cpu_wr.addr[7:0] == ZBORDER_PORT_LO;
    assign zvpage_match  = cpu_wr.addr == ZVPAGE_PORT;

    always_ff @(posedge clk)
    begin
        if (reset)
            dec_valid <= 1'b0;
        else
            dec_valid <= cpu_wr.valid && (ext_match || zborder_match || zvpage_match);
    end

    always_ff @(posedge clk)
    begin
        dec_data <= cpu_wr.data;
        if (zvpage_match)
            dec_opcode <= REG_ZVPAGE;
        else if (zborder_match)
            dec_opcode <= REG_ZBORDER;
        else
            dec_opcode <= ext_opcode;
    end

    assign dec_wr = '{valid: dec_valid, opcode: dec_opcode, data: dec_data};

    // a valid opcode must be one of the register file's cases
    assert property (@(posedge clk) disable iff (reset)
        dec_wr.valid |-> ext_defined(dec_wr.opcode)
                         || dec_wr.opcode inside {REG_ZBORDER, REG_ZVPAGE})
        else $error("port_decoder emitted undefined opcode %h", dec_wr.opcode);

endmodule

// File: hw/video_ports.sv
// shadowed fields reach params only after the next line_start and zvpage writes bypass the shadow
`timescale 1ns/1ns

module video_ports
    import video_regs_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  port_wr_t      dec_wr,
    input  logic          line_start,
    input  logic          int_start,
    output video_params_t params
);

    logic [7:0]  vpage_s;
    logic [7:0]  vconf_s;
    logic [7:0]  palsel_s;
    logic [7:0]  t0gpage_s;
    logic [7:0]  t1gpage_s;
    logic [8:0]  gx_offs_s;
    logic [8:0]  t0x_offs_s;
    logic [8:0]  t1x_offs_s;

    logic        zvpage_wr;
    logic [7:0]  zvpage_val;
    logic        vint_wr;
    logic [3:0]  vint_inc;
    logic [8:0]  vint_sum;
    logic [8:0]  vint_next;
    logic [66:0] vis_shadowed;

    assign zvpage_wr  = dec_wr.valid && dec_wr.opcode == REG_ZVPAGE;
    assign zvpage_val = {6'b000001, dec_wr.data[3], 1'b1};
    assign vint_wr    = dec_wr.valid && dec_wr.opcode inside {REG_VINT_BEG_L, REG_VINT_BEG_H};

    assign vint_sum   = params.vint_beg + {5'd0, vint_inc};
    // past line 319 the top bits read 101, clearing them takes off 320
    assign vint_next  = {(vint_sum[8:6] == 3'b101) ? 3'b000 : vint_sum[8:6], vint_sum[5:0]};

    // **************************************************
    // shadow registers
    // **************************************************
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            vpage_s    <= VPAGE_RESET;
            vconf_s    <= '0;
            palsel_s   <= PALSEL_RESET;
            t0gpage_s  <= '0;
            t1gpage_s  <= '0;
            gx_offs_s  <= '0;
            t0x_offs_s <= '0;
            t1x_offs_s <= '0;
        end
        else if (dec_wr.valid)
        begin
            case (dec_wr.opcode)
                REG_VPAGE:      vpage_s         <= dec_wr.data;
                REG_ZVPAGE:     vpage_s         <= zvpage_val;
                REG_VCONF:      vconf_s         <= dec_wr.data;
                REG_PALSEL:     palsel_s        <= dec_wr.data;
                REG_T0GPAGE:    t0gpage_s       <= dec_wr.data;
                REG_T1GPAGE:    t1gpage_s       <= dec_wr.data;
                REG_GX_OFFS_L:  gx_offs_s[7:0]  <= dec_wr.data;
                REG_GX_OFFS_H:  gx_offs_s[8]    <= dec_wr.data[0];
                REG_T0X_OFFS_L: t0x_offs_s[7:0] <= dec_wr.data;
                REG_T0X_OFFS_H: t0x_offs_s[8]   <= dec_wr.data[0];
                REG_T1X_OFFS_L: t1x_offs_s[7:0] <= dec_wr.data;
                REG_T1X_OFFS_H: t1x_offs_s[8]   <= dec_wr.data[0];
                default:        ;
            endcase
        end
    end

    // **************************************************
    // visible parameters
    // **************************************************
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            params   <= '{vpage: VPAGE_RESET, palsel: PALSEL_RESET, hint_beg: HINT_RESET,
                          default: '0};
            vint_inc <= '0;
        end
        else
        begin
            if (line_start)
            begin
                params.vpage    <= vpage_s;
                params.vconf    <= vconf_s;
                params.palsel   <= palsel_s;
                params.t0gpage  <= t0gpage_s;
                params.t1gpage  <= t1gpage_s;
                params.gx_offs  <= gx_offs_s;
                params.t0x_offs <= t0x_offs_s;
                params.t1x_offs <= t1x_offs_s;
            end

            if (int_start && !vint_wr)
                params.vint_beg <= vint_next;

            if (dec_wr.valid)
            begin
                case (dec_wr.opcode)
                    REG_BORDER:     params.border        <= dec_wr.data;
                    REG_ZBORDER:    params.border        <= {params.palsel[3:0], 1'b0,
                                                             dec_wr.data[2:0]};
                    REG_ZVPAGE:     params.vpage         <= zvpage_val;    // beats line_start
                    REG_TSCONF:     params.tsconf        <= dec_wr.data;
                    REG_TMPAGE:     params.tmpage        <= dec_wr.data;
                    REG_SGPAGE:     params.sgpage        <= dec_wr.data;
                    REG_HINT_BEG:   params.hint_beg      <= dec_wr.data;
                    REG_GY_OFFS_L:  params.gy_offs[7:0]  <= dec_wr.data;
                    REG_GY_OFFS_H:  params.gy_offs[8]    <= dec_wr.data[0];
                    REG_T0Y_OFFS_L: params.t0y_offs[7:0] <= dec_wr.data;
                    REG_T0Y_OFFS_H: params.t0y_offs[8]   <= dec_wr.data[0];
                    REG_T1Y_OFFS_L: params.t1y_offs[7:0] <= dec_wr.data;
                    REG_T1Y_OFFS_H: params.t1y_offs[8]   <= dec_wr.data[0];
                    REG_VINT_BEG_L: params.vint_beg[7:0] <= dec_wr.data;
                    REG_VINT_BEG_H:
                    begin
                        params.vint_beg[8] <= dec_wr.data[0];
                        vint_inc           <= dec_wr.data[7:4];
                    end
                    default:        ;
                endcase
            end
        end
    end

    assign vis_shadowed = {params.vpage, params.vconf, params.palsel, params.t0gpage,
                           params.t1gpage, params.gx_offs, params.t0x_offs, params.t1x_offs};

    // the timer's line_start is the only path for staged values to become visible
    assert property (@(posedge clk) disable iff (reset)
        !$past(reset) && !$past(line_start) && !$past(zvpage_wr) |-> $stable(vis_shadowed))
        else $error("shadowed field changed outside line_start");

endmodule

// File: hw/raster_timer.sv
// free running raster with 448 clocks per line and 320 lines and no sync or blanking outputs
`timescale 1ns/1ns

module raster_timer
    import video_regs_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    output raster_pos_t pos,
    output logic        column_tick,
    output logic        line_start
);

    logic       phase;          // second clock of a column unit
    logic [7:0] col_cnt;
    logic [8:0] line_cnt;
    logic       last_column;
    logic       last_line;

    assign last_column = col_cnt == LINE_COLUMNS - 8'd1;
    assign last_line   = line_cnt == FRAME_LINES - 9'd1;

    // high on the clock whose edge moves the position on
    assign column_tick = phase;

    // **************************************************
    // counters
    // **************************************************
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            phase      <= 1'b0;
            col_cnt    <= '0;
            line_cnt   <= '0;
            line_start <= 1'b0;
        end
        else
        begin
            phase      <= ~phase;
            line_start <= phase && last_column;     // lands on first clock of column 0
            if (phase)
            begin
                if (last_column)
                begin
                    col_cnt  <= '0;
                    line_cnt <= last_line ? 9'd0 : line_cnt + 9'd1;
                end
                else
                    col_cnt <= col_cnt + 8'd1;
            end
        end
    end

    assign pos = '{line: line_cnt, column: col_cnt};

    assert property (@(posedge clk) disable iff (reset)
        pos.line < FRAME_LINES && pos.column < LINE_COLUMNS)
        else $error("raster position out of range %0d,%0d", pos.line, pos.column);

endmodule

// File: hw/raster_irq.sv
// matches the upcoming column unit so the pulse falls in its first clock and hint_beg above 223 never fires
`timescale 1ns/1ns

module raster_irq
    import video_regs_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  raster_pos_t pos,
    input  logic        column_tick,
    input  logic [7:0]  hint_beg,
    input  logic [8:0]  vint_beg,
    output logic        int_start
);

    logic       last_column;
    logic [7:0] next_column;
    logic [8:0] next_line;
    logic       hit;

    assign last_column = pos.column == LINE_COLUMNS - 8'd1;
    assign next_column = last_column ? 8'd0 : pos.column + 8'd1;

    always_comb
    begin
        if (!last_column)
            next_line = pos.line;
        else if (pos.line == FRAME_LINES - 9'd1)
            next_line = 9'd0;
        else
            next_line = pos.line + 9'd1;
    end

    assign hit = column_tick && next_line == vint_beg && next_column == hint_beg;

    always_ff @(posedge clk)
    begin
        if (reset)
            int_start <= 1'b0;
        else
            int_start <= hit;
    end

    assert property (@(posedge clk) disable iff (reset)
        int_start |=> !int_start)
        else $error("int_start held for two clocks");

endmodule

// File: hw/video_ctrl_top.sv
// single clock video control block whose cpu writes are never back-pressured
`timescale 1ns/1ns

module video_ctrl_top
    import video_regs_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  cpu_wr_t       cpu_wr,
    output video_params_t params,
    output raster_pos_t   pos,
    output logic          line_start,
    output logic          int_start
);

    port_wr_t dec_wr;
    logic     column_tick;

    // **************************************************
    // write pipeline
    // **************************************************
    port_decoder i_port_decoder (
        .clk    (clk),
        .reset  (reset),
        .cpu_wr (cpu_wr),
        .dec_wr (dec_wr)
    );

    video_ports i_video_ports (
        .clk        (clk),
        .reset      (reset),
        .dec_wr     (dec_wr),
        .line_start (line_start),
        .int_start  (int_start),
        .params     (params)
    );

    // **************************************************
    // raster and interrupt
    // **************************************************
    raster_timer i_raster_timer (
        .clk         (clk),
        .reset       (reset),
        .pos         (pos),
        .column_tick (column_tick),
        .line_start  (line_start)
    );

    raster_irq i_raster_irq (
        .clk         (clk),
        .reset       (reset),
        .pos         (pos),
        .column_tick (column_tick),
        .hint_beg    (params.hint_beg),
        .vint_beg    (params.vint_beg),     // steps after every pulse
        .int_start   (int_start)
    );

endmodule

// File: verification/tb_video_ctrl.sv
// expects the tsconf port map and a raster that runs freely from reset and needs about three frames of run time
`timescale 1ns/1ns

module tb_video_ctrl
    import video_regs_pkg::*;
();

    typedef enum logic [1:0] {K_IMM, K_SHD, K_LEG, K_INT} kind_e;

    typedef struct packed {
        kind_e       kind;
        logic [15:0] addr;
        logic [7:0]  data;
        logic        rnd;       // data byte drawn at run time
        logic [1:0]  pulses;    // interrupt pulses to follow the write
    } row_t;

    localparam longint LINE_CLKS  = 2 * longint'(LINE_COLUMNS);
    localparam longint FRAME_CLKS = LINE_CLKS * longint'(FRAME_LINES);

    logic          clk = 1'b0;
    logic          reset;
    cpu_wr_t       cpu_wr;
    video_params_t params;
    raster_pos_t   pos;
    logic          line_start;
    logic          int_start;

    video_params_t exp_p;       // reference copy of the visible parameters
    logic [3:0]    exp_inc;
    row_t          rows[$];
    int            test_errs;
    int            pass_cnt = 0;
    int            fail_cnt = 0;

    always #4 clk = ~clk;

    video_ctrl_top i_video_ctrl_top (
        .clk        (clk),
        .reset      (reset),
        .cpu_wr     (cpu_wr),
        .params     (params),
        .pos        (pos),
        .line_start (line_start),
        .int_start  (int_start)
    );

    // **************************************************
    // reference model
    // **************************************************
    function automatic video_params_t apply_write(video_params_t p, logic [15:0] addr,
                                                  logic [7:0] data, inout logic [3:0] inc);
        if (addr == ZVPAGE_PORT)
            p.vpage = {6'b000001, data[3], 1'b1};
        else if (addr[7:0] == ZBORDER_PORT_LO)
            p.border = {p.palsel[3:0], 1'b0, data[2:0]};
        else if (addr[7:0] == EXT_PORT_LO)
        begin
            case (video_reg_e'(addr[15:8]))
                REG_BORDER:     p.border        = data;
                REG_VPAGE:      p.vpage         = data;
                REG_VCONF:      p.vconf         = data;
                REG_PALSEL:     p.palsel        = data;
                REG_TSCONF:     p.tsconf        = data;
                REG_TMPAGE:     p.tmpage        = data;
                REG_T0GPAGE:    p.t0gpage       = data;
                REG_T1GPAGE:    p.t1gpage       = data;
                REG_SGPAGE:     p.sgpage        = data;
                REG_HINT_BEG:   p.hint_beg      = data;
                REG_GX_OFFS_L:  p.gx_offs[7:0]  = data;
                REG_GX_OFFS_H:  p.gx_offs[8]    = data[0];
                REG_GY_OFFS_L:  p.gy_offs[7:0]  = data;
                REG_GY_OFFS_H:  p.gy_offs[8]    = data[0];
                REG_T0X_OFFS_L: p.t0x_offs[7:0] = data;
                REG_T0X_OFFS_H: p.t0x_offs[8]   = data[0];
                REG_T0Y_OFFS_L: p.t0y_offs[7:0] = data;
                REG_T0Y_OFFS_H: p.t0y_offs[8]   = data[0];
                REG_T1X_OFFS_L: p.t1x_offs[7:0] = data;
                REG_T1X_OFFS_H: p.t1x_offs[8]   = data[0];
                REG_T1Y_OFFS_L: p.t1y_offs[7:0] = data;
                REG_T1Y_OFFS_H: p.t1y_offs[8]   = data[0];
                REG_VINT_BEG_L: p.vint_beg[7:0] = data;
                REG_VINT_BEG_H:
                begin
                    p.vint_beg[8] = data[0];
                    inc           = data[7:4];
                end
                default:        ;               // undefined high byte is dropped
            endcase
        end
        return p;
    endfunction

    function automatic logic [8:0] next_vint(logic [8:0] v, logic [3:0] inc);
        logic [8:0] s;
        s = v + 9'(inc);
        if (s[8:6] == 3'b101)
            s[8:6] = 3'b000;                    // past line 319
        return s;
    endfunction

    // **************************************************
    // drivers and compare tasks
    // **************************************************
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_write(input logic [15:0] addr, input logic [7:0] data);
        cpu_wr = '{valid: 1'b1, addr: addr, data: data};
        step();
        cpu_wr.valid = 1'b0;
    endtask

    task automatic compare_field(input string name, input logic [8:0] e, input logic [8:0] a);
        if (e !== a)
        begin
            $display("ERROR %s expected 0x%h actual 0x%h", name, e, a);
            test_errs++;
        end
    endtask

    task automatic check_params(input video_params_t e, input video_params_t a);
        compare_field("params.border", 9'(e.border), 9'(a.border));
        compare_field("params.vpage", 9'(e.vpage), 9'(a.vpage));
        compare_field("params.vconf", 9'(e.vconf), 9'(a.vconf));
        compare_field("params.palsel", 9'(e.palsel), 9'(a.palsel));
        compare_field("params.tsconf", 9'(e.tsconf), 9'(a.tsconf));
        compare_field("params.tmpage", 9'(e.tmpage), 9'(a.tmpage));
        compare_field("params.t0gpage", 9'(e.t0gpage), 9'(a.t0gpage));
        compare_field("params.t1gpage", 9'(e.t1gpage), 9'(a.t1gpage));
        compare_field("params.sgpage", 9'(e.sgpage), 9'(a.sgpage));
        compare_field("params.hint_beg", 9'(e.hint_beg), 9'(a.hint_beg));
        compare_field("params.gx_offs", e.gx_offs, a.gx_offs);
        compare_field("params.gy_offs", e.gy_offs, a.gy_offs);
        compare_field("params.t0x_offs", e.t0x_offs, a.t0x_offs);
        compare_field("params.t0y_offs", e.t0y_offs, a.t0y_offs);
        compare_field("params.t1x_offs", e.t1x_offs, a.t1x_offs);
        compare_field("params.t1y_offs", e.t1y_offs, a.t1y_offs);
        compare_field("params.vint_beg", e.vint_beg, a.vint_beg);
    endtask

    task automatic check_pos(input raster_pos_t e, input raster_pos_t a);
        compare_field("pos.line", e.line, a.line);
        compare_field("pos.column", 9'(e.column), 9'(a.column));
    endtask

    task automatic check_strobe(input string name, input logic e, input logic a);
        if (e !== a)
        begin
            $display("ERROR %s expected 0x%h actual 0x%h", name, e, a);
            test_errs++;
        end
    endtask

    task automatic wait_pulse(input logic want_int, input longint limit, output longint waited);
        waited = 0;
        do
        begin
            step();
            waited++;
        end
        while ((want_int ? int_start : line_start) !== 1'b1 && waited < limit);
        if ((want_int ? int_start : line_start) !== 1'b1)
        begin
            $display("timed out waiting for %s", want_int ? "int_start" : "line_start");
            test_errs++;
        end
    endtask

    task automatic end_test(input string what);
        if (test_errs == 0)
            pass_cnt++;
        else
            fail_cnt++;
        $display("%-44s %s", what, (test_errs == 0) ? "ok" : "FAIL");
    endtask

    task automatic add_row(input kind_e kind, input logic [15:0] addr, input logic [7:0] data,
                           input logic rnd, input logic [1:0] pulses);
        rows.push_back('{kind: kind, addr: addr, data: data, rnd: rnd, pulses: pulses});
    endtask

    // **************************************************
    // stimulus table and test sequence
    // **************************************************
    initial
    begin
        row_t          r;
        logic [7:0]    d;
        longint        waited;
        longint        spacing;
        raster_pos_t   want_pos;
        video_params_t nxt;

        void'($urandom(6938));
        cpu_wr = '0;
        reset  = 1'b1;

        add_row(K_IMM, 16'h0FAF, 8'h00, 1'b1, 2'd0);
        add_row(K_IMM, 16'h04AF, 8'hA5, 1'b0, 2'd0);
        add_row(K_IMM, 16'h05AF, 8'h01, 1'b0, 2'd0);
        add_row(K_IMM, 16'h06AF, 8'h00, 1'b1, 2'd0);
        add_row(K_IMM, 16'h16AF, 8'h00, 1'b1, 2'd0);
        add_row(K_IMM, 16'h19AF, 8'h00, 1'b1, 2'd0);
        add_row(K_IMM, 16'h42AF, 8'h3C, 1'b0, 2'd0);
        add_row(K_IMM, 16'h43AF, 8'h01, 1'b0, 2'd0);
        add_row(K_IMM, 16'h46AF, 8'h00, 1'b1, 2'd0);
        add_row(K_IMM, 16'h47AF, 8'h01, 1'b0, 2'd0);
        add_row(K_IMM, 16'h12AF, 8'h55, 1'b0, 2'd0);    // undefined extended register
        add_row(K_IMM, 16'h34FF, 8'h77, 1'b0, 2'd0);    // unknown port
        add_row(K_SHD, 16'h01AF, 8'h00, 1'b1, 2'd0);
        add_row(K_SHD, 16'h00AF, 8'h83, 1'b0, 2'd0);
        add_row(K_SHD, 16'h07AF, 8'h3A, 1'b0, 2'd0);
        add_row(K_SHD, 16'h02AF, 8'h00, 1'b1, 2'd0);
        add_row(K_SHD, 16'h03AF, 8'h01, 1'b0, 2'd0);
        add_row(K_SHD, 16'h40AF, 8'h00, 1'b1, 2'd0);
        add_row(K_SHD, 16'h41AF, 8'h01, 1'b0, 2'd0);
        add_row(K_SHD, 16'h44AF, 8'h00, 1'b1, 2'd0);
        add_row(K_SHD, 16'h45AF, 8'h01, 1'b0, 2'd0);
        add_row(K_SHD, 16'h17AF, 8'h42, 1'b0, 2'd0);
        add_row(K_SHD, 16'h18AF, 8'h9C, 1'b0, 2'd0);
        add_row(K_LEG, 16'h00FE, 8'h00, 1'b1, 2'd0);
        add_row(K_LEG, 16'h7FFD, 8'h08, 1'b0, 2'd0);
        add_row(K_INT, 16'h22AF, 8'h10, 1'b0, 2'd0);
        add_row(K_INT, 16'h23AF, 8'h38, 1'b0, 2'd0);
        add_row(K_INT, 16'h24AF, 8'h81, 1'b0, 2'd3);    // line 312, step 8, wraps to 0
        add_row(K_INT, 16'h24AF, 8'h00, 1'b0, 2'd2);    // zero step, once per frame

        exp_p   = '{vpage: VPAGE_RESET, palsel: PALSEL_RESET, hint_beg: HINT_RESET,
                    default: '0};
        exp_inc = '0;
        repeat (4) @(posedge clk);
        #1;
        reset     = 1'b0;
        test_errs = 0;
        want_pos  = '0;
        check_params(exp_p, params);
        check_pos(want_pos, pos);
        check_strobe("line_start", 1'b0, line_start);
        check_strobe("int_start", 1'b0, int_start);
        end_test("reset values");

        foreach (rows[i])
        begin
            r         = rows[i];
            test_errs = 0;
            d         = r.rnd ? 8'($urandom) : r.data;
            if (r.kind == K_SHD)
            begin
                wait_pulse(1'b0, 2 * LINE_CLKS, waited);    // keep the write clear of line_start
                step();
            end
            nxt = apply_write(exp_p, r.addr, d, exp_inc);
            drive_write(r.addr, d);
            check_params(exp_p, params);
            step();
            if (r.kind != K_SHD)
                exp_p = nxt;
            check_params(exp_p, params);
            if (r.kind == K_SHD)
            begin
                wait_pulse(1'b0, 2 * LINE_CLKS, waited);
                check_params(exp_p, params);
                step();
                exp_p = nxt;
                check_params(exp_p, params);
            end

            spacing = longint'((exp_inc == 4'd0) ? FRAME_LINES : 9'(exp_inc)) * LINE_CLKS;
            for (int k = 0; k < int'(r.pulses); k++)
            begin
                wait_pulse(1'b1, 2 * FRAME_CLKS, waited);
                if (k > 0 && waited + 1 != spacing)
                begin
                    $display("int_start pulses were %0d clocks apart instead of %0d",
                             waited + 1, spacing);
                    test_errs++;
                end
                want_pos.line   = exp_p.vint_beg;
                want_pos.column = exp_p.hint_beg;
                check_pos(want_pos, pos);
                step();
                exp_p.vint_beg = next_vint(exp_p.vint_beg, exp_inc);
                check_params(exp_p, params);
                check_strobe("int_start", 1'b0, int_start);
            end
            end_test($sformatf("row %0d %s addr 0x%h data 0x%h", i, r.kind.name(), r.addr, d));
        end

        $display("%0d tests ok, %0d tests with errors", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    // watchdog sized to two frames per table row
    initial
    begin
        longint limit_ns;
        #1;
        limit_ns = (longint'(rows.size()) * 2 * FRAME_CLKS + 10000) * 8;
        #(limit_ns);
        $display("watchdog expired after %0d ns with tests still running", limit_ns);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: sim.f
hw/video_regs_pkg.sv
hw/port_decoder.sv
hw/video_ports.sv
hw/raster_timer.sv
hw/raster_irq.sv
hw/video_ctrl_top.sv
verification/tb_video_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator from sim.f, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_video_ctrl \
    -f sim.f -o tb_video_ctrl
./obj_dir/tb_video_ctrl | tee sim.log

if grep -q "Simulation failed" sim.log || ! grep -q "Simulation passed" sim.log; then
    echo "run_sim: failure found in sim.log"
    exit 1
fi
echo "run_sim: no failure in sim.log"
